/* logic/controller_defines.svh */
`ifndef CONTROLLER_DEFINES_SVH
`define CONTROLLER_DEFINES_SVH

// instruction field widths
`define OP_WIDTH 4   // op, opExt and cond are all this wide

// processor status register
`define PSR_WIDTH 8

// every datapath select bus
`define SEL_WIDTH 2

// psr bit positions
`define FLAG_N 0    // negative / signed greater
`define FLAG_Z 1    // zero
`define FLAG_F 2    // overflow
`define FLAG_L 3    // unsigned lower
`define FLAG_C 4    // carry

`endif

/* logic/controllerPkg.sv */
`include "controller_defines.svh"

package controllerPkg;

    typedef enum logic [4:0] {
        FETCH, DECODE,
        BASIC_LOAD_REGS, IMM_LOAD_REGS, BASIC_ALU_EX, IMM_ALU_EX, WRITEBACK,
        CMP_LOAD_REG, CMPI_LOAD_REG, CMP_ALU_EX, CMPI_ALU_EX,
        MOV_LOAD_REG, MOVI_LOAD_REG, MOV_ALU_EX, MOVI_ALU_EX,
        LOAD_REG, STOR_REG, MEM_READ, MEM_WRITE, LOAD_WB,
        JAL_REG, JAL_STORE_PC, JAL_NEW_PC,
        JCOND_EX, BCOND_EX,
        PC_INCR, PC_INCR2, PC_INCR3
    } ctrlState_e;

    typedef enum logic [`OP_WIDTH-1:0] {
        OP_SIMPLE = 4'b0000, OP_ANDI = 4'b0001, OP_ORI  = 4'b0010, OP_XORI  = 4'b0011,
        OP_MEM    = 4'b0100, OP_ADDI = 4'b0101, OP_LSH  = 4'b1000, OP_SUBI  = 4'b1001,
        OP_CMPI   = 4'b1011, OP_BCOND = 4'b1100, OP_MOVI = 4'b1101, OP_LUI  = 4'b1111
    } opcode_e;

    // opExt values under OP_SIMPLE
    typedef enum logic [`OP_WIDTH-1:0] {
        AND = 4'b0001, OR  = 4'b0010, XOR = 4'b0011, ADD = 4'b0101,
        SUB = 4'b1001, CMP = 4'b1011, MOV = 4'b1101, MUL = 4'b1110
    } simpleExt_e;

    // opExt values under OP_MEM
    typedef enum logic [`OP_WIDTH-1:0] {
        LOAD = 4'b0000, STOR = 4'b0100, JAL = 4'b1000, JCOND = 4'b1100
    } memExt_e;

    typedef enum logic [3:0] {
        CL_BASIC, CL_IMM, CL_CMP, CL_CMPI, CL_MOV, CL_MOVI,
        CL_LOAD, CL_STOR, CL_JAL, CL_JCOND, CL_BCOND, CL_NONE
    } instrClass_e;

    typedef enum logic [`OP_WIDTH-1:0] {
        EQ, NE, CS, CC, HI, LS, GT, LE,
        FS, FC, LO, HS, LT, GE, UC, NV
    } condCode_e;

    typedef enum logic [`SEL_WIDTH-1:0] {PC_SEQ = 2'd0, PC_ABS = 2'd1, PC_REL = 2'd2} pcSrc_e;
    typedef enum logic [`SEL_WIDTH-1:0] {A_PC = 2'd0, A_REG = 2'd1, A_ZERO = 2'd2} aluSrc1_e;
    typedef enum logic [`SEL_WIDTH-1:0] {B_REG = 2'd0, B_IMM = 2'd1} aluSrc2_e;

    typedef struct packed {
        logic [`OP_WIDTH-1:0] op;
        logic [`OP_WIDTH-1:0] opExt;
        logic [`OP_WIDTH-1:0] cond;
    } instrFields_t;

    // datapath control lines, one bundle per cycle
    typedef struct packed {
        logic     memWrite;
        logic     pcEn;              // pc write strobe
        logic     writeBackSelect;   // memory data to register file
        logic     dataToWriteSelect; // link address to register file
        logic     newAluInput;
        logic     psrRegEn;
        logic     regWrite;
        logic     instrWrite;
        logic     sendPcAddr;
        aluSrc1_e aluSrc1Sel;
        aluSrc2_e aluSrc2Sel;
        pcSrc_e   pcSrc;
    } ctrlBundle_t;

endpackage

/* logic/opDecoder.sv */
`timescale 1ns/1ps
`include "controller_defines.svh"

module opDecoder (
    input  controllerPkg::instrFields_t instr,
    output controllerPkg::instrClass_e  instrClass
);

    // register form of the shift; every other opExt under OP_LSH is LSHI
    localparam logic [`OP_WIDTH-1:0] LSH_REG_EXT = 4'b0100;

    logic neverTaken;

    assign neverTaken = (instr.cond == controllerPkg::NV);

    always_comb
    begin
        instrClass = controllerPkg::CL_NONE;
        case (instr.op)
            controllerPkg::OP_SIMPLE:
            begin
                case (instr.opExt)
                    controllerPkg::ADD, controllerPkg::SUB, controllerPkg::MUL,
                    controllerPkg::AND, controllerPkg::OR, controllerPkg::XOR:
                        instrClass = controllerPkg::CL_BASIC;
                    controllerPkg::CMP: instrClass = controllerPkg::CL_CMP;
                    controllerPkg::MOV: instrClass = controllerPkg::CL_MOV;
                    default: ;
                endcase
            end
            controllerPkg::OP_LSH:
            begin
                if (instr.opExt == LSH_REG_EXT)
                    instrClass = controllerPkg::CL_BASIC;
                else
                    instrClass = controllerPkg::CL_IMM; // LSHI
            end
            controllerPkg::OP_MEM:
            begin
                case (instr.opExt)
                    controllerPkg::LOAD: instrClass = controllerPkg::CL_LOAD;
                    controllerPkg::STOR: instrClass = controllerPkg::CL_STOR;
                    controllerPkg::JAL:  instrClass = controllerPkg::CL_JAL;
                    controllerPkg::JCOND:
                        if (!neverTaken)
                            instrClass = controllerPkg::CL_JCOND;
                    default: ;
                endcase
            end
            controllerPkg::OP_ADDI, controllerPkg::OP_SUBI, controllerPkg::OP_ANDI,
            controllerPkg::OP_ORI, controllerPkg::OP_XORI, controllerPkg::OP_LUI:
                instrClass = controllerPkg::CL_IMM;
            controllerPkg::OP_CMPI: instrClass = controllerPkg::CL_CMPI;
            controllerPkg::OP_MOVI: instrClass = controllerPkg::CL_MOVI;
            controllerPkg::OP_BCOND:
                if (!neverTaken)
                    instrClass = controllerPkg::CL_BCOND;
            default: ; // unused opcodes just step the pc
        endcase
    end

endmodule

/* logic/branchCondition.sv */
`timescale 1ns/1ps
`include "controller_defines.svh"

module branchCondition (
    input  controllerPkg::condCode_e cond,
    input  logic [`PSR_WIDTH-1:0]    psr,
    output logic                     taken
);

    logic flagN;
    logic flagZ;
    logic flagF;
    logic flagL;
    logic flagC;

    assign flagN = psr[`FLAG_N];
    assign flagZ = psr[`FLAG_Z];
    assign flagF = psr[`FLAG_F];
    assign flagL = psr[`FLAG_L];
    assign flagC = psr[`FLAG_C];

    always_comb
    begin
        taken = 1'b0;
        case (cond)
            controllerPkg::EQ: taken = flagZ;
            controllerPkg::NE: taken = !flagZ;
            controllerPkg::CS: taken = flagC;
            controllerPkg::CC: taken = !flagC;
            controllerPkg::HI: taken = flagL;
            controllerPkg::LS: taken = !flagL;
            controllerPkg::GT: taken = flagN;
            controllerPkg::LE: taken = !flagN;
            controllerPkg::FS: taken = flagF;
            controllerPkg::FC: taken = !flagF;
            // unsigned pair uses L together with Z
            controllerPkg::LO: taken = !flagL && !flagZ;
            controllerPkg::HS: taken = flagL || flagZ;
            // signed pair uses N together with Z
            controllerPkg::LT: taken = !flagN && !flagZ;
            controllerPkg::GE: taken = flagN || flagZ;
            controllerPkg::UC: taken = 1'b1;
            controllerPkg::NV: taken = 1'b0;
            default: taken = 1'b0;
        endcase
    end

endmodule

/* logic/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  controllerPkg::instrClass_e instrClass,
    output controllerPkg::ctrlState_e  state
);

    controllerPkg::ctrlState_e nextState;

    always_ff @(posedge clk)
    begin
        if (!reset)
            state <= controllerPkg::FETCH;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = controllerPkg::PC_INCR;
        case (state)
            controllerPkg::FETCH: nextState = controllerPkg::DECODE;
            controllerPkg::DECODE:
            begin
                // class is only looked at here
                case (instrClass)
                    controllerPkg::CL_BASIC: nextState = controllerPkg::BASIC_LOAD_REGS;
                    controllerPkg::CL_IMM:   nextState = controllerPkg::IMM_LOAD_REGS;
                    controllerPkg::CL_CMP:   nextState = controllerPkg::CMP_LOAD_REG;
                    controllerPkg::CL_CMPI:  nextState = controllerPkg::CMPI_LOAD_REG;
                    controllerPkg::CL_MOV:   nextState = controllerPkg::MOV_LOAD_REG;
                    controllerPkg::CL_MOVI:  nextState = controllerPkg::MOVI_LOAD_REG;
                    controllerPkg::CL_LOAD:  nextState = controllerPkg::LOAD_REG;
                    controllerPkg::CL_STOR:  nextState = controllerPkg::STOR_REG;
                    controllerPkg::CL_JAL:   nextState = controllerPkg::JAL_REG;
                    controllerPkg::CL_JCOND: nextState = controllerPkg::JCOND_EX;
                    controllerPkg::CL_BCOND: nextState = controllerPkg::BCOND_EX;
                    default:                 nextState = controllerPkg::PC_INCR;
                endcase
            end
            controllerPkg::BASIC_LOAD_REGS: nextState = controllerPkg::BASIC_ALU_EX;
            controllerPkg::IMM_LOAD_REGS:   nextState = controllerPkg::IMM_ALU_EX;
            controllerPkg::CMP_LOAD_REG:    nextState = controllerPkg::CMP_ALU_EX;
            controllerPkg::CMPI_LOAD_REG:   nextState = controllerPkg::CMPI_ALU_EX;
            controllerPkg::MOV_LOAD_REG:    nextState = controllerPkg::MOV_ALU_EX;
            controllerPkg::MOVI_LOAD_REG:   nextState = controllerPkg::MOVI_ALU_EX;
            controllerPkg::BASIC_ALU_EX, controllerPkg::IMM_ALU_EX,
            controllerPkg::MOV_ALU_EX, controllerPkg::MOVI_ALU_EX:
                nextState = controllerPkg::WRITEBACK;
            // compares only touch the psr
            controllerPkg::CMP_ALU_EX, controllerPkg::CMPI_ALU_EX:
                nextState = controllerPkg::PC_INCR;
            controllerPkg::WRITEBACK:       nextState = controllerPkg::PC_INCR;
            controllerPkg::LOAD_REG:        nextState = controllerPkg::MEM_READ;
            controllerPkg::MEM_READ:        nextState = controllerPkg::LOAD_WB;
            controllerPkg::LOAD_WB:         nextState = controllerPkg::PC_INCR;
            controllerPkg::STOR_REG:        nextState = controllerPkg::MEM_WRITE;
            controllerPkg::MEM_WRITE:       nextState = controllerPkg::PC_INCR;
            controllerPkg::JAL_REG:         nextState = controllerPkg::JAL_STORE_PC;
            controllerPkg::JAL_STORE_PC:    nextState = controllerPkg::JAL_NEW_PC;
            controllerPkg::JAL_NEW_PC:      nextState = controllerPkg::PC_INCR;
            // branch states already wrote the pc
            controllerPkg::JCOND_EX, controllerPkg::BCOND_EX:
                nextState = controllerPkg::PC_INCR2;
            controllerPkg::PC_INCR:         nextState = controllerPkg::PC_INCR2;
            controllerPkg::PC_INCR2:        nextState = controllerPkg::PC_INCR3;
            controllerPkg::PC_INCR3:        nextState = controllerPkg::FETCH;
            default:                        nextState = controllerPkg::PC_INCR;
        endcase
    end

    stateLegal: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(state) && (state <= controllerPkg::PC_INCR3))
        else $error("illegal controller state %0d", state);

    decodeDispatches: assert property (@(posedge clk) disable iff (!reset)
        (state == controllerPkg::DECODE) |=>
            (state != controllerPkg::FETCH) && (state != controllerPkg::DECODE))
        else $error("DECODE did not dispatch, state %0d", state);

endmodule

/* logic/controlOutputs.sv */
`timescale 1ns/1ps

module controlOutputs (
    input  controllerPkg::ctrlState_e  state,
    input  logic                       taken,
    output controllerPkg::ctrlBundle_t ctrl
);

    always_comb
    begin
        ctrl = '0;
        case (state)
            controllerPkg::FETCH: ctrl.instrWrite = 1'b1;
            // operand latch for every class that reads registers
            controllerPkg::BASIC_LOAD_REGS, controllerPkg::IMM_LOAD_REGS,
            controllerPkg::CMP_LOAD_REG, controllerPkg::CMPI_LOAD_REG,
            controllerPkg::MOV_LOAD_REG, controllerPkg::MOVI_LOAD_REG,
            controllerPkg::LOAD_REG, controllerPkg::STOR_REG,
            controllerPkg::JAL_REG:
                ctrl.newAluInput = 1'b1;
            controllerPkg::BASIC_ALU_EX:
                ctrl.aluSrc1Sel = controllerPkg::A_REG;
            controllerPkg::IMM_ALU_EX:
            begin
                ctrl.aluSrc1Sel = controllerPkg::A_REG;
                ctrl.aluSrc2Sel = controllerPkg::B_IMM;
            end
            controllerPkg::CMP_ALU_EX:
            begin
                ctrl.aluSrc1Sel = controllerPkg::A_REG;
                ctrl.psrRegEn   = 1'b1;
            end
            controllerPkg::CMPI_ALU_EX:
            begin
                ctrl.aluSrc1Sel = controllerPkg::A_REG;
                ctrl.aluSrc2Sel = controllerPkg::B_IMM;
                ctrl.psrRegEn   = 1'b1; // flags set as for CMP
            end
            controllerPkg::MOV_ALU_EX:
                ctrl.aluSrc1Sel = controllerPkg::A_ZERO; // src + 0
            controllerPkg::MOVI_ALU_EX:
            begin
                ctrl.aluSrc1Sel = controllerPkg::A_ZERO;
                ctrl.aluSrc2Sel = controllerPkg::B_IMM;
            end
            controllerPkg::WRITEBACK: ctrl.regWrite = 1'b1;
            controllerPkg::MEM_WRITE: ctrl.memWrite = 1'b1;
            controllerPkg::LOAD_WB:
            begin
                ctrl.writeBackSelect = 1'b1;
                ctrl.regWrite        = 1'b1;
            end
            controllerPkg::JAL_STORE_PC:
            begin
                ctrl.dataToWriteSelect = 1'b1; // link address
                ctrl.regWrite          = 1'b1;
            end
            controllerPkg::JAL_NEW_PC:
            begin
                ctrl.pcSrc = controllerPkg::PC_ABS;
                ctrl.pcEn  = 1'b1;
            end
            controllerPkg::JCOND_EX:
            begin
                ctrl.pcEn = 1'b1;
                if (taken)
                    ctrl.pcSrc = controllerPkg::PC_ABS;
            end
            controllerPkg::BCOND_EX:
            begin
                ctrl.pcEn = 1'b1;
                if (taken)
                    ctrl.pcSrc = controllerPkg::PC_REL;
            end
            controllerPkg::PC_INCR:  ctrl.pcEn = 1'b1;
            controllerPkg::PC_INCR3: ctrl.sendPcAddr = 1'b1; // next fetch address out
            default: ; // DECODE, MEM_READ and PC_INCR2 drive nothing
        endcase
    end

    // register file and memory are never written in the same cycle
    always_comb
    begin
        assert (!(ctrl.regWrite && ctrl.memWrite))
            else $error("regWrite with memWrite in state %0d", state);
        assert (ctrl.pcEn || (ctrl.pcSrc == controllerPkg::PC_SEQ))
            else $error("pc source %0d selected without pcEn", ctrl.pcSrc);
    end

endmodule

/* logic/multicycleController.sv */
`timescale 1ns/1ps
`include "controller_defines.svh"

module multicycleController (
    input  logic                        clk,
    input  logic                        reset,
    input  controllerPkg::instrFields_t instr,
    input  logic [`PSR_WIDTH-1:0]       psr,
    output controllerPkg::ctrlBundle_t  ctrl
);

    controllerPkg::instrClass_e instrClass;
    controllerPkg::ctrlState_e  state;
    logic                       taken;

    opDecoder decoder (
        .instr      (instr),
        .instrClass (instrClass)
    );

    branchCondition condEval (
        .cond  (controllerPkg::condCode_e'(instr.cond)),
        .psr   (psr),
        .taken (taken)
    );

    controlSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .state      (state)
    );

    // taken only matters in the two branch states
    controlOutputs outputs (
        .state (state),
        .taken (taken),
        .ctrl  (ctrl)
    );

endmodule

/* verif/controllerModel.svh */
`ifndef CONTROLLER_MODEL_SVH
`define CONTROLLER_MODEL_SVH

typedef enum {
    M_BASIC, M_IMM, M_CMP, M_CMPI, M_MOV, M_MOVI,
    M_LOAD, M_STOR, M_JAL, M_JCOND, M_BCOND, M_NONE
} modelKind_e;

// expected ctrl for each remaining cycle of the current instruction
controllerPkg::ctrlBundle_t expectQ[$];

function automatic modelKind_e classify(logic [3:0] op, logic [3:0] opExt, logic [3:0] cond);
    modelKind_e kind;
    kind = M_NONE;
    case (op)
        4'b0000:
        begin
            if (opExt inside {4'b0001, 4'b0010, 4'b0011, 4'b0101, 4'b1001, 4'b1110})
                kind = M_BASIC;
            else if (opExt == 4'b1011)
                kind = M_CMP;
            else if (opExt == 4'b1101)
                kind = M_MOV;
        end
        4'b1000: kind = (opExt == 4'b0100) ? M_BASIC : M_IMM; // LSH or LSHI
        4'b0100:
        begin
            case (opExt)
                4'b0000: kind = M_LOAD;
                4'b0100: kind = M_STOR;
                4'b1000: kind = M_JAL;
                4'b1100: kind = (cond == 4'hf) ? M_NONE : M_JCOND;
                default: kind = M_NONE;
            endcase
        end
        4'b0001, 4'b0010, 4'b0011, 4'b0101, 4'b1001, 4'b1111: kind = M_IMM;
        4'b1011: kind = M_CMPI;
        4'b1101: kind = M_MOVI;
        4'b1100: kind = (cond == 4'hf) ? M_NONE : M_BCOND;
        default: kind = M_NONE; // 0110, 0111, 1010 and 1110 are unused
    endcase
    return kind;
endfunction

function automatic logic branchTaken(logic [3:0] cond, logic [`PSR_WIDTH-1:0] flags);
    logic n, z, f, l, c;
    logic result;
    n = flags[`FLAG_N];
    z = flags[`FLAG_Z];
    f = flags[`FLAG_F];
    l = flags[`FLAG_L];
    c = flags[`FLAG_C];
    case (cond)
        4'd0:    result = z;
        4'd1:    result = !z;
        4'd2:    result = c;
        4'd3:    result = !c;
        4'd4:    result = l;
        4'd5:    result = !l;
        4'd6:    result = n;
        4'd7:    result = !n;
        4'd8:    result = f;
        4'd9:    result = !f;
        4'd10:   result = !l && !z;
        4'd11:   result = l || z;
        4'd12:   result = !n && !z;
        4'd13:   result = n || z;
        4'd14:   result = 1'b1;
        default: result = 1'b0; // never
    endcase
    return result;
endfunction

task automatic latchOperands();
    controllerPkg::ctrlBundle_t b;
    b = '0;
    b.newAluInput = 1'b1;
    expectQ.push_back(b);
endtask

// tail of every instruction, optionally with the PC_INCR write
task automatic stepPc(input logic withIncrement);
    controllerPkg::ctrlBundle_t b;
    b = '0;
    b.pcEn = 1'b1;
    if (withIncrement)
        expectQ.push_back(b);
    b = '0;
    expectQ.push_back(b);
    b.sendPcAddr = 1'b1;
    expectQ.push_back(b);
endtask

task automatic planInstruction(input logic [3:0] op, input logic [3:0] opExt,
                               input logic [3:0] cond, input logic [`PSR_WIDTH-1:0] flags);
    controllerPkg::ctrlBundle_t b;
    modelKind_e kind;
    kind = classify(op, opExt, cond);
    b = '0;
    b.instrWrite = 1'b1;
    expectQ.push_back(b);  // fetch
    b = '0;
    expectQ.push_back(b);  // decode
    case (kind)
        M_BASIC, M_IMM, M_CMP, M_CMPI, M_MOV, M_MOVI:
        begin
            latchOperands();
            b = '0;
            b.aluSrc1Sel = (kind == M_MOV || kind == M_MOVI) ? controllerPkg::A_ZERO
                                                             : controllerPkg::A_REG;
            if (kind == M_IMM || kind == M_CMPI || kind == M_MOVI)
                b.aluSrc2Sel = controllerPkg::B_IMM;
            b.psrRegEn = (kind == M_CMP || kind == M_CMPI);
            expectQ.push_back(b);
            if (!b.psrRegEn)
            begin
                b = '0;
                b.regWrite = 1'b1;
                expectQ.push_back(b);
            end
            stepPc(1'b1);
        end
        M_LOAD:
        begin
            latchOperands();
            b = '0;
            expectQ.push_back(b);  // memory read
            b.writeBackSelect = 1'b1;
            b.regWrite = 1'b1;
            expectQ.push_back(b);
            stepPc(1'b1);
        end
        M_STOR:
        begin
            latchOperands();
            b = '0;
            b.memWrite = 1'b1;
            expectQ.push_back(b);
            stepPc(1'b1);
        end
        M_JAL:
        begin
            latchOperands();
            b = '0;
            b.dataToWriteSelect = 1'b1;
            b.regWrite = 1'b1;
            expectQ.push_back(b);
            b = '0;
            b.pcEn = 1'b1;
            b.pcSrc = controllerPkg::PC_ABS;
            expectQ.push_back(b);
            stepPc(1'b1);
        end
        M_JCOND, M_BCOND:
        begin
            b = '0;
            b.pcEn = 1'b1;
            if (branchTaken(cond, flags))
                b.pcSrc = (kind == M_JCOND) ? controllerPkg::PC_ABS : controllerPkg::PC_REL;
            expectQ.push_back(b);
            stepPc(1'b0);
        end
        default: stepPc(1'b1);
    endcase
endtask

`endif

/* verif/controllerTb.sv */
`timescale 1ns/1ps
`include "controller_defines.svh"

module controllerTb;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 8 + 100; // 8 cycles is the longest instruction

    logic                        clk;
    logic                        reset;
    controllerPkg::instrFields_t instr;
    logic [`PSR_WIDTH-1:0]       psr;
    controllerPkg::ctrlBundle_t  ctrl;

    int cycleCount = 0;
    int issued = 0;

    `include "controllerModel.svh"

    multicycleController DUT (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .psr   (psr),
        .ctrl  (ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES)
        begin
            $display("timeout: instruction stream still running after %0d cycles", cycleCount);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic checkValue(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR %s: got 0x%h, expected 0x%h (instruction %0d, cycle %0d)",
                     name, actual, expected, issued, cycleCount);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkBundle(input controllerPkg::ctrlBundle_t expected);
        checkValue("ctrl.memWrite", 8'(ctrl.memWrite), 8'(expected.memWrite));
        checkValue("ctrl.pcEn", 8'(ctrl.pcEn), 8'(expected.pcEn));
        checkValue("ctrl.writeBackSelect", 8'(ctrl.writeBackSelect), 8'(expected.writeBackSelect));
        checkValue("ctrl.dataToWriteSelect", 8'(ctrl.dataToWriteSelect),
                   8'(expected.dataToWriteSelect));
        checkValue("ctrl.newAluInput", 8'(ctrl.newAluInput), 8'(expected.newAluInput));
        checkValue("ctrl.psrRegEn", 8'(ctrl.psrRegEn), 8'(expected.psrRegEn));
        checkValue("ctrl.regWrite", 8'(ctrl.regWrite), 8'(expected.regWrite));
        checkValue("ctrl.instrWrite", 8'(ctrl.instrWrite), 8'(expected.instrWrite));
        checkValue("ctrl.sendPcAddr", 8'(ctrl.sendPcAddr), 8'(expected.sendPcAddr));
        checkValue("ctrl.aluSrc1Sel", 8'(ctrl.aluSrc1Sel), 8'(expected.aluSrc1Sel));
        checkValue("ctrl.aluSrc2Sel", 8'(ctrl.aluSrc2Sel), 8'(expected.aluSrc2Sel));
        checkValue("ctrl.pcSrc", 8'(ctrl.pcSrc), 8'(expected.pcSrc));
    endtask

    // weighted toward the mem and branch groups so every cond shows up on a branch
    function automatic controllerPkg::instrFields_t randomInstr();
        controllerPkg::instrFields_t f;
        logic [31:0] raw;
        int unsigned pick;
        raw = $urandom;
        pick = $urandom % 10;
        f.cond = raw[3:0];
        f.opExt = raw[7:4];
        case (pick)
            0, 1:
            begin
                f.op = 4'b0100;
                if (raw[11:10] != 2'b00)
                    f.opExt = {raw[9:8], 2'b00}; // LOAD, STOR, JAL or JCOND
            end
            2: f.op = 4'b1100;
            3: f.op = 4'b0000;
            4: f.op = 4'b1000;
            default: f.op = raw[15:12]; // unused opcodes too
        endcase
        return f;
    endfunction

    initial
    begin
        controllerPkg::instrFields_t nextInstr;
        controllerPkg::ctrlBundle_t  expected;
        logic [31:0]                 raw;
        logic [`PSR_WIDTH-1:0]       nextPsr;
        logic                        newInstr;

        reset = 1'b0;
        instr = '0;
        psr = '0;
        void'($urandom(32'ha503));
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;  // state is FETCH from here on
        while (issued < NUM_INSTR || expectQ.size() != 0)
        begin
            newInstr = 1'b0;
            if (expectQ.size() == 0)
            begin
                nextInstr = randomInstr();
                raw = $urandom;
                nextPsr = raw[`PSR_WIDTH-1:0];
                planInstruction(nextInstr.op, nextInstr.opExt, nextInstr.cond, nextPsr);
                issued++;
                newInstr = 1'b1;
            end
            expected = expectQ.pop_front();
            checkBundle(expected);
            if (newInstr)
            begin
                instr = nextInstr;  // held until the next fetch
                psr = nextPsr;
            end
            @(negedge clk);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
+incdir+verif
logic/controllerPkg.sv
logic/opDecoder.sv
logic/branchCondition.sv
logic/controlSequencer.sv
logic/controlOutputs.sv
logic/multicycleController.sv
verif/controllerTb.sv

/* run.sh */
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module controllerTb -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VcontrollerTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
